//--- isaPkg.sv
`default_nettype none

package isaPkg;

   typedef logic [15:0] wordT;
   typedef logic [1:0] regIdxT;

   // Opcodes
   localparam logic [3:0] opBne = 4'd0;
   localparam logic [3:0] opBeq = 4'd1;
   localparam logic [3:0] opBgz = 4'd2;
   localparam logic [3:0] opBlz = 4'd3;
   localparam logic [3:0] opAdi = 4'd4;
   localparam logic [3:0] opOri = 4'd5;
   localparam logic [3:0] opLhi = 4'd6;
   localparam logic [3:0] opLwd = 4'd7;
   localparam logic [3:0] opSwd = 4'd8;
   localparam logic [3:0] opJmp = 4'd9;
   localparam logic [3:0] opJal = 4'd10;
   localparam logic [3:0] opRtype = 4'd15;

   // Function codes of the register group
   localparam logic [5:0] fnAdd = 6'd0;
   localparam logic [5:0] fnSub = 6'd1;
   localparam logic [5:0] fnAnd = 6'd2;
   localparam logic [5:0] fnOr = 6'd3;
   localparam logic [5:0] fnNot = 6'd4;
   localparam logic [5:0] fnTcp = 6'd5;
   localparam logic [5:0] fnShl = 6'd6;
   localparam logic [5:0] fnShr = 6'd7;
   localparam logic [5:0] fnJpr = 6'd25;
   localparam logic [5:0] fnJrl = 6'd26;
   localparam logic [5:0] fnWwd = 6'd28;
   localparam logic [5:0] fnHlt = 6'd29;

   // Return address register of JAL and JRL
   localparam regIdxT linkReg = 2'd2;

   typedef union packed {
      struct packed {
         logic [3:0] opcode;
         regIdxT rs;
         regIdxT rt;
         regIdxT rd;
         logic [5:0] funct;
      } r;
      struct packed {
         logic [3:0] opcode;
         regIdxT rs;
         regIdxT rt;
         logic [7:0] imm;
      } i;
      struct packed {
         logic [3:0] opcode;
         logic [11:0] target;
      } j;
   } instrT;

endpackage

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

package ctrlPkg;

   typedef enum logic [4:0] {
      FETCH_REQ = 5'd0,
      FETCH_WAIT = 5'd1,
      DECODE = 5'd2,
      EXEC = 5'd3,
      MEM_REQ = 5'd4,
      MEM_WAIT = 5'd5,
      WRITEBACK = 5'd6,
      HALTED = 5'd7
   } stateT;

   // Data operations
   typedef enum logic [3:0] {
      ADD = 4'd0,
      SUB = 4'd1,
      AND = 4'd2,
      OR = 4'd3,
      NOT = 4'd4,
      NEG = 4'd5,
      SHL = 4'd6,
      SHR = 4'd7,
      LHI = 4'd8,
      PASS = 4'd9,
      // Branch conditions
      NE = 4'd10,
      EQ = 4'd11,
      GTZ = 4'd12,
      LTZ = 4'd13
   } aluOpT;

endpackage

`default_nettype wire

//--- regFile.sv
`default_nettype none

module regFile (
   input  bit             clk,
   input  bit             rstN,
   input  isaPkg::regIdxT rdAddrA,
   input  isaPkg::regIdxT rdAddrB,
   input  isaPkg::regIdxT wrAddr,
   input  isaPkg::wordT   wrData,
   input  bit             wrEn,
   output isaPkg::wordT   rdDataA,
   output isaPkg::wordT   rdDataB
);

   import isaPkg::*;

   wordT regs [4];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
   input  isaPkg::wordT   a,
   input  isaPkg::wordT   b,
   input  ctrlPkg::aluOpT op,
   output isaPkg::wordT   result,
   output bit             bcond
);

   import ctrlPkg::*;

   always_comb begin
      result = '0;
      bcond = 1'b0;
      case (op)
         ADD: result = a + b;
         SUB: result = a - b;
         AND: result = a & b;
         OR: result = a | b;
         NOT: result = ~a;
         NEG: result = ~a + 16'd1;
         SHL: result = a << 1;
         // Logical shift that clears the sign bit
         SHR: result = a >> 1;
         // Immediate into the upper byte
         LHI: result = {b[7:0], 8'h00};
         PASS: result = a;
         NE: bcond = (a != b);
         EQ: bcond = (a == b);
         // Positive and nonzero
         GTZ: bcond = !a[15] && (a != '0);
         LTZ: bcond = a[15];
         default: begin
            result = '0;
            bcond = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- datapath.sv
`default_nettype none

module datapath (
   input  bit             clk,
   input  bit             rstN,
   input  bit             irLoad,
   input  bit             mdrLoad,
   input  bit             pcLoad,
   input  bit             regWrite,
   input  bit             memToReg,
   input  bit             aluSrcImm,
   input  bit             signExtend,
   input  bit             savePc,
   input  bit             branch,
   input  bit             jumpTarget,
   input  bit             jumpReg,
   input  bit             addrFromAlu,
   input  bit             outLoad,
   input  ctrlPkg::aluOpT aluOp,
   input  isaPkg::wordT   memRdata,
   output isaPkg::wordT   memAddr,
   output isaPkg::wordT   memWdata,
   output isaPkg::instrT  instr,
   output bit             bcond,
   output isaPkg::wordT   outPort,
   output bit             outValid
);

   import isaPkg::*;

   wordT   pc;
   wordT   pcPlus1;
   wordT   mdr;
   wordT   imm;
   wordT   rdDataA;
   wordT   rdDataB;
   wordT   aluB;
   wordT   aluResult;
   wordT   nextPc;
   wordT   wrData;
   regIdxT wrAddr;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
         instr <= '0;
         outValid <= 1'b0;
      end else begin
         if (pcLoad) begin
            pc <= nextPc;
         end
         if (irLoad) begin
            instr <= memRdata;
         end
         outValid <= outLoad;
      end
   end

   // Load data and the output word
   always_ff @(posedge clk) begin
      if (mdrLoad) begin
         mdr <= memRdata;
      end
      if (outLoad) begin
         outPort <= rdDataA;
      end
   end

   assign pcPlus1 = pc + 16'd1;
   assign imm = signExtend ? {{8{instr.i.imm[7]}}, instr.i.imm} : {8'h00, instr.i.imm};
   assign aluB = aluSrcImm ? imm : rdDataB;
   assign memAddr = addrFromAlu ? aluResult : pc;
   assign memWdata = rdDataB;

   always_comb begin
      if (jumpReg) begin
         nextPc = rdDataA;
      end else if (jumpTarget) begin
         nextPc = {pcPlus1[15:12], instr.j.target};
      end else if (branch) begin
         nextPc = pcPlus1 + imm;
      end else begin
         nextPc = pcPlus1;
      end
   end

   // Immediate forms write rt and register forms write rd
   assign wrAddr = savePc ? linkReg : (aluSrcImm ? instr.i.rt : instr.r.rd);
   assign wrData = savePc ? pcPlus1 : (memToReg ? mdr : aluResult);

   regFile rf (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (instr.r.rs),
      .rdAddrB (instr.r.rt),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .wrEn    (regWrite),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

   alu aluUnit (
      .a      (rdDataA),
      .b      (aluB),
      .op     (aluOp),
      .result (aluResult),
      .bcond  (bcond)
   );

endmodule

`default_nettype wire

//--- controller.sv
`default_nettype none

module controller (
   input  bit             clk,
   input  bit             rstN,
   input  isaPkg::instrT  instr,
   input  bit             bcond,
   input  bit             memAck,
   output bit             memReq,
   output bit             memWrite,
   output bit             irLoad,
   output bit             mdrLoad,
   output bit             pcLoad,
   output bit             regWrite,
   output bit             memToReg,
   output bit             aluSrcImm,
   output bit             signExtend,
   output bit             savePc,
   output bit             branch,
   output bit             jumpTarget,
   output bit             jumpReg,
   output bit             addrFromAlu,
   output bit             outLoad,
   output ctrlPkg::aluOpT aluOp,
   output isaPkg::wordT   numInst,
   output bit             halted
);

   import isaPkg::*;
   import ctrlPkg::*;

   stateT      state;
   stateT      nextState;
   logic [3:0] opcode;
   logic [5:0] funct;
   logic       isRgroup;
   logic       isAluR;
   logic       isAluI;
   logic       isLoad;
   logic       isStore;
   logic       isBranch;
   logic       isJal;
   logic       isJrl;
   logic       isJmp;
   logic       isJpr;
   logic       isWwd;
   logic       isHlt;
   logic       ackSeen;
   logic       instDone;

   assign opcode = instr.r.opcode;
   assign funct = instr.r.funct;
   assign isRgroup = (opcode == opRtype);
   assign isAluR = isRgroup && (funct <= fnShr);
   assign isAluI = opcode inside {opAdi, opOri, opLhi};
   assign isLoad = (opcode == opLwd);
   assign isStore = (opcode == opSwd);
   assign isBranch = opcode inside {opBne, opBeq, opBgz, opBlz};
   assign isJmp = (opcode == opJmp);
   assign isJal = (opcode == opJal);
   assign isJpr = isRgroup && (funct == fnJpr);
   assign isJrl = isRgroup && (funct == fnJrl);
   assign isWwd = isRgroup && (funct == fnWwd);
   assign isHlt = isRgroup && (funct == fnHlt);

   // Memory answered an outstanding request
   assign ackSeen = memReq && memAck;

   always_comb begin
      nextState = state;
      case (state)
         FETCH_REQ: if (ackSeen) nextState = FETCH_WAIT;
         FETCH_WAIT: if (!memAck) nextState = DECODE;
         DECODE: begin
            if (isHlt) begin
               nextState = HALTED;
            end else if (isAluR || isAluI || isLoad || isStore || isBranch) begin
               nextState = EXEC;
            end else if (isJal || isJrl) begin
               nextState = WRITEBACK;
            end else begin
               // JMP, JPR, WWD and unknown codes finish here
               nextState = FETCH_REQ;
            end
         end
         EXEC: begin
            if (isLoad || isStore) begin
               nextState = MEM_REQ;
            end else if (isBranch) begin
               nextState = FETCH_REQ;
            end else begin
               nextState = WRITEBACK;
            end
         end
         MEM_REQ: if (ackSeen) nextState = MEM_WAIT;
         MEM_WAIT: if (!memAck) nextState = isLoad ? WRITEBACK : FETCH_REQ;
         WRITEBACK: nextState = FETCH_REQ;
         HALTED: nextState = HALTED;
         default: nextState = FETCH_REQ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= FETCH_REQ;
         memReq <= 1'b0;
         memWrite <= 1'b0;
         numInst <= '0;
      end else begin
         state <= nextState;
         memReq <= nextState inside {FETCH_REQ, MEM_REQ};
         memWrite <= (nextState == MEM_REQ) && isStore;
         if (instDone) begin
            numInst <= numInst + 16'd1;
         end
      end
   end

   // Every instruction but halt ends on its way back to fetch
   assign pcLoad = (state != FETCH_REQ) && (nextState == FETCH_REQ);
   assign instDone = pcLoad || ((state == DECODE) && isHlt);

   assign irLoad = (state == FETCH_REQ) && ackSeen;
   assign mdrLoad = (state == MEM_REQ) && ackSeen && isLoad;
   assign regWrite = (state == WRITEBACK);
   assign outLoad = (state == DECODE) && isWwd;
   assign addrFromAlu = state inside {MEM_REQ, MEM_WAIT};
   assign memToReg = isLoad;
   assign aluSrcImm = isAluI || isLoad || isStore;
   assign signExtend = (opcode != opOri);
   assign savePc = isJal || isJrl;
   assign branch = isBranch && bcond;
   assign jumpTarget = isJmp || isJal;
   assign jumpReg = isJpr || isJrl;
   assign halted = (state == HALTED);

   always_comb begin
      case (opcode)
         opBne: aluOp = NE;
         opBeq: aluOp = EQ;
         opBgz: aluOp = GTZ;
         opBlz: aluOp = LTZ;
         opOri: aluOp = OR;
         opLhi: aluOp = LHI;
         // ADI and the address of LWD and SWD
         opAdi, opLwd, opSwd: aluOp = ADD;
         opRtype: begin
            case (funct)
               fnAdd: aluOp = ADD;
               fnSub: aluOp = SUB;
               fnAnd: aluOp = AND;
               fnOr: aluOp = OR;
               fnNot: aluOp = NOT;
               fnTcp: aluOp = NEG;
               fnShl: aluOp = SHL;
               fnShr: aluOp = SHR;
               default: aluOp = PASS;
            endcase
         end
         default: aluOp = PASS;
      endcase
   end

endmodule

`default_nettype wire

//--- cpuTop.sv
`default_nettype none

module cpuTop (
   input  bit           clk,
   input  bit           rstN,
   output bit           memReq,
   output bit           memWrite,
   output isaPkg::wordT memAddr,
   output isaPkg::wordT memWdata,
   input  bit           memAck,
   input  isaPkg::wordT memRdata,
   output isaPkg::wordT outPort,
   output bit           outValid,
   output isaPkg::wordT numInst,
   output bit           halted
);

   import isaPkg::*;
   import ctrlPkg::*;

   instrT instr;
   aluOpT aluOp;
   bit    bcond;
   bit    irLoad;
   bit    mdrLoad;
   bit    pcLoad;
   bit    regWrite;
   bit    memToReg;
   bit    aluSrcImm;
   bit    signExtend;
   bit    savePc;
   bit    branch;
   bit    jumpTarget;
   bit    jumpReg;
   bit    addrFromAlu;
   bit    outLoad;

   controller ctrl (.*);

   datapath dp (.*);

endmodule

`default_nettype wire

//--- cpuTop_sva.sv
`default_nettype none

module cpuTopSva (
   input bit           clk,
   input bit           rstN,
   input bit           memReq,
   input bit           memWrite,
   input isaPkg::wordT memAddr,
   input isaPkg::wordT memWdata,
   input bit           memAck,
   input bit           halted
);

   int violations = 0;

   // Request stays up until the memory answers
   reqHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
      memReq && !memAck |=> memReq)
      else begin
         violations++;
         $error("memReq dropped before memAck");
      end

   reqFieldsStable: assert property (@(posedge clk) disable iff (!rstN)
      memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWrite) && $stable(memWdata))
      else begin
         violations++;
         $error("memory request fields changed while memReq was high");
      end

   haltSticky: assert property (@(posedge clk) disable iff (!rstN)
      halted |=> halted)
      else begin
         violations++;
         $error("halted fell after being set");
      end

   // No memory traffic once stopped
   quietWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
      halted |-> !memReq)
      else begin
         violations++;
         $error("memReq raised while halted");
      end

endmodule

`default_nettype wire

//--- cpuChecker.sv
`default_nettype none

module cpuChecker (
   input bit           clk,
   input bit           rstN,
   input bit           memReq,
   input bit           memWrite,
   input isaPkg::wordT memAddr,
   input isaPkg::wordT memWdata,
   input bit           memAck,
   input isaPkg::wordT outPort,
   input bit           outValid,
   input isaPkg::wordT numInst,
   input bit           halted
);

   import isaPkg::*;

   wordT expOut [$];
   wordT expAddr [$];
   wordT expData [$];
   wordT expCount;
   int   outIdx;
   int   storeIdx;
   int   passCount;
   int   failCount;

   task automatic expectOut(input wordT data);
      expOut.push_back(data);
   endtask

   task automatic expectStore(input wordT addr, input wordT data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic expectCount(input wordT count);
      expCount = count;
   endtask

   task automatic compare(input string what, input wordT expected, input wordT actual);
      if (actual === expected) begin
         passCount++;
         $display("ok  %s = 0x%04h", what, actual);
      end else begin
         failCount++;
         $display("ERR %s expected 0x%04h actual 0x%04h", what, expected, actual);
      end
   endtask

   task automatic reportFailure(input string msg);
      failCount++;
      $display("%s", msg);
   endtask

   // Port values are settled by the falling edge
   always @(negedge clk) begin
      if (rstN && outValid) begin
         if (expOut.size() == 0) begin
            reportFailure($sformatf("Output word 0x%04h was not expected", outPort));
         end else begin
            compare($sformatf("outPort[%0d]", outIdx), expOut.pop_front(), outPort);
         end
         outIdx++;
      end
      // Request and answer overlap for one cycle per access
      if (rstN && memReq && memAck && memWrite) begin
         if (expAddr.size() == 0) begin
            reportFailure($sformatf("Store of 0x%04h to 0x%04h was not expected",
                                    memWdata, memAddr));
         end else begin
            compare($sformatf("memAddr[%0d]", storeIdx), expAddr.pop_front(), memAddr);
            compare($sformatf("memWdata[%0d]", storeIdx), expData.pop_front(), memWdata);
         end
         storeIdx++;
      end
   end

   task automatic summarize(input int assertFails, output int fails);
      compare("halted", 16'd1, {15'd0, halted});
      compare("numInst", expCount, numInst);
      if (expOut.size() != 0) begin
         reportFailure($sformatf("%0d expected output words never appeared", expOut.size()));
      end
      if (expAddr.size() != 0) begin
         reportFailure($sformatf("%0d expected stores never happened", expAddr.size()));
      end
      if (assertFails != 0) begin
         reportFailure($sformatf("%0d assertion failures on the memory port or halt",
                                 assertFails));
      end
      $display("checks passed %0d failed %0d", passCount, failCount);
      fails = failCount;
   endtask

endmodule

`default_nettype wire

//--- tbCpu.sv
`default_nettype none

module tbCpu;

   import isaPkg::*;

   bit     clk;
   bit     rstN;
   bit     memReq;
   bit     memWrite;
   wordT   memAddr;
   wordT   memWdata;
   bit     memAck;
   wordT   memRdata;
   wordT   outPort;
   bit     outValid;
   wordT   numInst;
   bit     halted;

   wordT   mem [256];
   integer seed;
   int     expCount;
   int     cycles;
   int     fails;
   bit     traceOk;

   cpuTop uut (.*);

   cpuChecker chk (.*);

   bind cpuTop cpuTopSva sva (.*);

   always #5 clk = ~clk;

   task automatic loadTrace(output bit ok);
      int         fd;
      int         code;
      int         ch;
      int         k;
      logic [7:0] tag;
      wordT       addr;
      wordT       data;
      ok = 1'b0;
      fd = $fopen("cpu_trace.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         code = $fscanf(fd, " %c", tag);
         while (code == 1) begin
            case (tag)
               // Base address followed by eight program words
               "M": begin
                  code = $fscanf(fd, " %h", addr);
                  for (k = 0; k < 8; k++) begin
                     code = $fscanf(fd, " %h", data);
                     mem[addr[7:0] + k] = data;
                  end
               end
               "O": begin
                  code = $fscanf(fd, " %h", data);
                  chk.expectOut(data);
               end
               "W": begin
                  code = $fscanf(fd, " %h %h", addr, data);
                  chk.expectStore(addr, data);
               end
               "N": begin
                  code = $fscanf(fd, " %h", data);
                  expCount = data;
                  chk.expectCount(data);
               end
               default: begin
                  // Comment line
                  ch = $fgetc(fd);
                  while (ch != "\n" && ch != -1) begin
                     ch = $fgetc(fd);
                  end
               end
            endcase
            code = $fscanf(fd, " %c", tag);
         end
         $fclose(fd);
      end
   endtask

   // Memory answers each request after 0 to 3 cycles
   initial begin : memModel
      int waitCycles;
      memAck = 1'b0;
      memRdata = '0;
      forever begin
         @(posedge clk);
         #1;
         if (rstN && memReq && !memAck) begin
            waitCycles = $random(seed) & 3;
            repeat (waitCycles) begin
               @(posedge clk);
               #1;
            end
            if (memWrite) begin
               mem[memAddr[7:0]] = memWdata;
            end
            memRdata = mem[memAddr[7:0]];
            memAck = 1'b1;
            // Hold the answer until the request drops
            while (memReq) begin
               @(posedge clk);
               #1;
            end
            memAck = 1'b0;
         end
      end
   end

   initial begin
      rstN = 1'b0;
      seed = 32'h3df0_f93b;
      expCount = 0;
      fails = 0;
      loadTrace(traceOk);
      repeat (3) @(posedge clk);
      #1;
      rstN = 1'b1;
      cycles = 0;
      // Twenty cycles covers the slowest instruction
      while (traceOk && !halted && cycles < (expCount + 1) * 20) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!traceOk) begin
         $display("Could not open cpu_trace.txt");
         $display("TEST FAILED");
      end else if (!halted) begin
         $display("Timeout: CPU did not halt within %0d cycles", cycles);
         $display("TEST FAILED");
      end else begin
         // Stray outputs after halt would show up here
         repeat (10) @(posedge clk);
         #1;
         chk.summarize(uut.sva.violations, fails);
         if (fails == 0) begin
            $display("TEST OK");
         end else begin
            $display("TEST FAILED");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- cpu_trace.txt
# M: base address, then eight program words; O: expected output word
# W: expected store address and data; N: expected instruction count; all hex
M 0000 6112 5534 F41C 429A F81C F6C0 FC1C F6C1
M 0008 FC1C F6C2 FC1C F6C3 FC1C F6C4 FC1C F6C5
M 0010 FC1C F6C6 FC1C FAC7 FC1C 539A FC1C 4060
M 0018 8100 8205 83FF 7300 FC1C 7105 F41C 72FF
M 0020 F81C 0601 F01C 1601 FC1C 1F01 F41C 0F01
M 0028 F81C 2801 F41C 2401 F01C 3401 F81C 3801
M 0030 F41C 9034 F01C F01C A040 41E8 F41A F41C
M 0038 F01D F01D F01D F01D F01D F01D F01D F01D
M 0040 F81C F819 F01C F01D F01D F01D F01D F01D
M 0048 F81C F819 F01C F01D F01D F01D F01D F01D
O 1234
O FF9A
O 11CE
O 129A
O 1210
O FFBE
O EDCB
O EDCC
O 2468
O 7FCD
O 009A
O 1234
O FF9A
O 009A
O 1234
O 009A
O 0060
O FF9A
O 0035
O 0037
O 0048
W 0060 1234
W 0065 FF9A
W 005F 009A
N 0037

//--- sources.f
isaPkg.sv
ctrlPkg.sv
regFile.sv
alu.sv
datapath.sv
controller.sv
cpuTop.sv
cpuTop_sva.sv
cpuChecker.sv
tbCpu.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - isaPkg.sv
  - ctrlPkg.sv
  - regFile.sv
  - alu.sv
  - datapath.sv
  - controller.sv
  - cpuTop.sv
  - target: test
    files:
      - cpuTop_sva.sv
      - cpuChecker.sv
      - tbCpu.sv
